// File: cpu16Top.f
+incdir+verilog
+incdir+testbench
verilog/cpu16Pkg.sv
verilog/instrDecoder.sv
verilog/controlFsm.sv
verilog/execUnit.sv
verilog/apbRequester.sv
verilog/cpu16Top.sv
testbench/cpu16Tb_sva.sv
testbench/cpu16Tb.sv

// File: testbench/cpu16Model.svh
`ifndef CPU16_MODEL_SVH
`define CPU16_MODEL_SVH

// Architectural state of the reference model, one instruction per modelStep
logic [`CPU16_DATA_W-1:0] modelReg [`CPU16_REG_CNT];
logic [`CPU16_DATA_W-1:0] modelPc;
logic [`CPU16_DATA_W-1:0] modelMem [256];

task automatic checkValue(input string name, input logic [`CPU16_DATA_W-1:0] expected,
		input logic [`CPU16_DATA_W-1:0] actual);
	checkCount++;
	if (actual !== expected) begin
		errorCount++;
		$display("MISMATCH at %0t ns: %s expected %h actual %h", $time, name, expected, actual);
	end
endtask

task automatic modelReset();
	for (int i = 0; i < 256; i++) begin
		modelMem[i] = mem[i];
	end
	for (int r = 0; r < `CPU16_REG_CNT; r++) begin
		modelReg[r] = '0;
	end
	modelPc = '0;
endtask

// Shifts by 16 or more clear the word
function automatic logic [`CPU16_DATA_W-1:0] aluResult(input logic [2:0] funct,
		input logic [`CPU16_DATA_W-1:0] a, input logic [`CPU16_DATA_W-1:0] b);
	case (funct)
		3'd0:    return a & b;
		3'd1:    return a + b;
		3'd2:    return a - b;
		3'd3:    return (b > 15) ? '0 : a << b[3:0];
		default: return (b > 15) ? '0 : a >> b[3:0];
	endcase
endfunction

task automatic modelStep(output logic memAccess, output logic memWrite,
		output logic [`CPU16_DATA_W-1:0] memAddr, output logic [`CPU16_DATA_W-1:0] memData);
	logic [`CPU16_DATA_W-1:0] instr;
	logic [`CPU16_DATA_W-1:0] pcInc;
	logic [`CPU16_DATA_W-1:0] imm;
	logic [`CPU16_REG_W-1:0]  rt;
	logic [`CPU16_REG_W-1:0]  rs;
	instr     = modelMem[modelPc[7:0]];
	pcInc     = modelPc + 1;
	rt        = instr[11:9];
	rs        = instr[8:6];
	imm       = {{(`CPU16_DATA_W - `CPU16_IMM_W){instr[`CPU16_IMM_W-1]}},
		instr[`CPU16_IMM_W-1:0]};
	memAccess = 1'b0;
	memWrite  = 1'b0;
	memAddr   = modelReg[rs] + imm;   // Only meaningful for LW and SW
	memData   = modelReg[rt];
	modelPc   = pcInc;
	case (instr[15:12])
		cpu16Pkg::RTYPE: modelReg[instr[5:3]] = aluResult(instr[2:0], modelReg[rt], modelReg[rs]);
		cpu16Pkg::ADDI:  modelReg[rt] = modelReg[rt] + imm;
		cpu16Pkg::ANDI:  modelReg[rt] = modelReg[rt] & imm;
		cpu16Pkg::LW: begin
			memAccess    = 1'b1;
			modelReg[rt] = modelMem[memAddr[7:0]];
		end
		cpu16Pkg::SW: begin
			memAccess                = 1'b1;
			memWrite                 = 1'b1;
			modelMem[memAddr[7:0]] = memData;
		end
		cpu16Pkg::BEQ: if (modelReg[rt] == modelReg[rs]) modelPc = pcInc + imm;
		cpu16Pkg::BNE: if (modelReg[rt] != modelReg[rs]) modelPc = pcInc + imm;
		cpu16Pkg::JMP: modelPc = {pcInc[15:12], instr[11:0]};
		default: ;
	endcase
	modelReg[0] = '0;     // r0 reads zero whatever was written
endtask

`endif

// File: testbench/cpu16Tb.sv
`timescale 1ns/1ns
`include "cpu16_params.svh"

module cpu16Tb;
	localparam int timeoutCycles = 200;
	localparam int dumpStart     = 63;                          // First SW of the register dump
	localparam int selfPc        = dumpStart + `CPU16_REG_CNT;  // JMP to itself

	logic                     clk;
	logic                     reset;
	cpu16Pkg::apbRspT         apbRsp;
	cpu16Pkg::apbReqT         apbReq;
	logic [`CPU16_DATA_W-1:0] mem [256];
	integer                   seed;
	int                       checkCount;
	int                       errorCount;
	logic                     timedOut;

	`include "cpu16Model.svh"

	cpu16Top u_dut (
		.clk    (clk),
		.reset  (reset),
		.apbRsp (apbRsp),
		.apbReq (apbReq)
	);

	always #10 clk = ~clk;

	function automatic logic [15:0] encode(input logic [3:0] op, input logic [2:0] rt,
			input logic [2:0] rs, input logic [5:0] low);
		return {op, rt, rs, low};
	endfunction

	task automatic buildProgram();
		int         kind;
		int         hop;
		logic [2:0] dst;
		logic [2:0] srcA;
		logic [2:0] srcB;
		logic [5:0] imm;
		logic [11:0] target;
		for (int i = 0; i < 256; i++) begin
			mem[i] = 16'($random(seed));
		end
		// r7 = 28 << 3 = 224 as the data region base
		mem[0] = encode(cpu16Pkg::ADDI, 3'd7, 3'd0, 6'd28);
		mem[1] = encode(cpu16Pkg::ADDI, 3'd6, 3'd0, 6'd3);
		mem[2] = encode(cpu16Pkg::RTYPE, 3'd7, 3'd6, {3'd7, 3'd3});
		for (int p = 3; p < dumpStart; p++) begin
			kind = $unsigned($random(seed)) % 10;
			dst  = 3'($unsigned($random(seed)) % 7);   // r7 is never overwritten
			srcA = 3'($random(seed));
			srcB = 3'($random(seed));
			imm  = 6'($random(seed));
			hop  = $unsigned($random(seed)) % 4;
			if (p + 1 + hop > dumpStart) hop = dumpStart - p - 1;
			if (kind >= 7 && ($random(seed) & 1)) srcB = srcA;   // Equal operands
			target = 12'(p + 1 + hop);
			case (kind)
				0, 1, 2: mem[p] = encode(cpu16Pkg::RTYPE, srcA, srcB,
					{dst, 3'($unsigned($random(seed)) % 5)});
				3:       mem[p] = encode(cpu16Pkg::ADDI, dst, 3'd0, imm);
				4:       mem[p] = encode(cpu16Pkg::ANDI, dst, 3'd0, imm);
				5:       mem[p] = encode(cpu16Pkg::LW, dst, 3'd7, imm);
				6:       mem[p] = encode(cpu16Pkg::SW, srcA, 3'd7, imm);
				7:       mem[p] = encode(cpu16Pkg::BEQ, srcA, srcB, 6'(hop));
				8:       mem[p] = encode(cpu16Pkg::BNE, srcA, srcB, 6'(hop));
				default: mem[p] = encode(cpu16Pkg::JMP, target[11:9], target[8:6], target[5:0]);
			endcase
		end
		for (int r = 0; r < `CPU16_REG_CNT; r++) begin
			mem[dumpStart + r] = encode(cpu16Pkg::SW, 3'(r), 3'd7, 6'(r - 32));
		end
		target      = 12'(selfPc);
		mem[selfPc] = encode(cpu16Pkg::JMP, target[11:9], target[8:6], target[5:0]);
	endtask

	// Memory responder for one transfer with 0 to 3 wait states
	task automatic serveTransfer(output logic isWrite, output logic [15:0] addr,
			output logic [15:0] wdata);
		int waits;
		int cycles;
		cycles  = 0;
		isWrite = 1'b0;
		addr    = '0;
		wdata   = '0;
		while (!(apbReq.psel && !apbReq.penable) && cycles < timeoutCycles) begin
			@(posedge clk);
			#2;
			cycles++;
		end
		if (cycles >= timeoutCycles) begin
			$display("Timeout at %0t ns: no APB transfer started in %0d cycles", $time, cycles);
			timedOut = 1'b1;
			errorCount++;
		end else begin
			isWrite = apbReq.pwrite;
			addr    = apbReq.paddr;
			wdata   = apbReq.pwdata;
			waits   = $unsigned($random(seed)) % 4;
			repeat (waits + 1) begin
				@(posedge clk);
				#2;
			end
			apbRsp.prdata = mem[addr[7:0]];
			apbRsp.pready = 1'b1;
			if (isWrite) mem[addr[7:0]] = wdata;
			@(posedge clk);
			#2;
			apbRsp.pready = 1'b0;
		end
	endtask

	task automatic runInstruction();
		logic        isWrite;
		logic        memAccess;
		logic        memWrite;
		logic [15:0] addr;
		logic [15:0] wdata;
		logic [15:0] memAddr;
		logic [15:0] memData;
		if (!timedOut) serveTransfer(isWrite, addr, wdata);
		if (!timedOut) begin
			checkValue("fetch pwrite", 1'b0, isWrite);
			checkValue("fetch paddr", modelPc, addr);
			modelStep(memAccess, memWrite, memAddr, memData);
			if (memAccess) serveTransfer(isWrite, addr, wdata);
			if (memAccess && !timedOut) begin
				checkValue("data pwrite", memWrite, isWrite);
				checkValue("data paddr", memAddr, addr);
				if (memWrite) checkValue("store pwdata", memData, wdata);
			end
		end
	endtask

	task automatic runUntil(input int stopPc);
		int steps;
		steps = 0;
		while (modelPc != stopPc && !timedOut && steps < timeoutCycles) begin
			runInstruction();
			steps++;
		end
		if (modelPc != stopPc && !timedOut) begin
			$display("Program did not reach address %0d within %0d instructions", stopPc, steps);
			errorCount++;
		end
	endtask

	task automatic reportTest(input string name, input int checksBefore, input int errorsBefore);
		$display("Test %s: %0d checks, %0d errors", name, checkCount - checksBefore,
			errorCount - errorsBefore);
	endtask

	initial begin
		int checksBefore;
		int errorsBefore;
		clk        = 1'b0;
		reset      = 1'b1;
		apbRsp     = '0;
		seed       = 35;
		checkCount = 0;
		errorCount = 0;
		timedOut   = 1'b0;
		buildProgram();
		modelReset();
		repeat (4) @(posedge clk);
		#2;
		checkValue("apbReq.psel", 1'b0, apbReq.psel);
		checkValue("apbReq.penable", 1'b0, apbReq.penable);
		checkValue("apbReq.pwrite", 1'b0, apbReq.pwrite);
		reset = 1'b0;
		runInstruction();     // First fetch reads address 0
		reportTest("reset and first fetch", 0, 0);
		checksBefore = checkCount;
		errorsBefore = errorCount;
		runUntil(dumpStart);
		reportTest("random program", checksBefore, errorsBefore);
		checksBefore = checkCount;
		errorsBefore = errorCount;
		runUntil(selfPc);
		reportTest("register dump", checksBefore, errorsBefore);
		checksBefore = checkCount;
		errorsBefore = errorCount;
		runInstruction();
		runInstruction();     // Fetch after the JMP lands on the JMP
		reportTest("jump to self", checksBefore, errorsBefore);
		errorCount += u_dut.uSva.failCount;     // Bound APB protocol assertions
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0 && !timedOut) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// File: testbench/cpu16Tb_sva.sv
`timescale 1ns/1ns

module cpu16Tb_sva (
	input logic             clk,
	input logic             reset,
	input cpu16Pkg::apbReqT apbReq,
	input cpu16Pkg::apbRspT apbRsp
);
	logic setupPhase;
	logic accessWait;
	int   failCount = 0;    // Assertion failures so far

	assign setupPhase = apbReq.psel && !apbReq.penable;
	assign accessWait = apbReq.psel && apbReq.penable && !apbRsp.pready;

	setupThenAccess: assert property (@(posedge clk) disable iff (reset)
		setupPhase |=> apbReq.psel && apbReq.penable)
		else begin
			failCount++;
			$error("APB setup cycle not followed by an access cycle");
		end

	penableAfterSetup: assert property (@(posedge clk) disable iff (reset)
		$rose(apbReq.penable) |-> $past(setupPhase))
		else begin
			failCount++;
			$error("penable rose without a setup cycle before it");
		end

	// Request fields hold from setup until pready
	requestStable: assert property (@(posedge clk) disable iff (reset)
		(setupPhase || accessWait) |=>
			$stable(apbReq.paddr) && $stable(apbReq.pwrite) && $stable(apbReq.pwdata))
		else begin
			failCount++;
			$error("APB request changed before the transfer completed");
		end

	selLowInReset: assert property (@(posedge clk) reset |-> !apbReq.psel)
		else begin
			failCount++;
			$error("psel high during reset");
		end

endmodule

bind cpu16Top cpu16Tb_sva uSva (
	.clk    (clk),
	.reset  (reset),
	.apbReq (apbReq),
	.apbRsp (apbRsp)
);

// File: verilog/apbRequester.sv
`timescale 1ns/1ns
`include "cpu16_params.svh"

module apbRequester (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     busStart,
	input  logic                     busWrite,
	input  logic [`CPU16_DATA_W-1:0] busAddr,
	input  logic [`CPU16_DATA_W-1:0] busWdata,
	input  cpu16Pkg::apbRspT         apbRsp,
	output cpu16Pkg::apbReqT         apbReq,
	output logic                     busDone,
	output logic [`CPU16_DATA_W-1:0] busRdata
);
	logic                     accessQ;  // Access phase in progress
	logic                     writeQ;
	logic [`CPU16_DATA_W-1:0] addrQ;
	logic [`CPU16_DATA_W-1:0] wdataQ;

	// Idle until busStart, which is itself the setup cycle
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			accessQ <= 1'b0;
			writeQ  <= 1'b0;
		end else if (busStart) begin
			accessQ <= 1'b1;
			writeQ  <= busWrite;
		end else if (busDone) begin
			accessQ <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (busStart) begin
			addrQ  <= busAddr;
			wdataQ <= busWdata;
		end
	end

	assign busDone  = accessQ && apbRsp.pready;
	assign busRdata = apbRsp.prdata;    // Sampled by the IR or MDR on busDone

	// Access cycles replay the values latched in setup
	always_comb begin
		apbReq.psel    = busStart || accessQ;
		apbReq.penable = accessQ;
		apbReq.pwrite  = accessQ ? writeQ : (busStart && busWrite);
		apbReq.paddr   = accessQ ? addrQ : busAddr;
		apbReq.pwdata  = accessQ ? wdataQ : busWdata;
	end

endmodule

// File: verilog/controlFsm.sv
`timescale 1ns/1ns
`include "cpu16_params.svh"

module controlFsm (
	input  logic              clk,
	input  logic              reset,
	input  cpu16Pkg::decodedT dec,
	input  logic              busDone,
	output cpu16Pkg::ctrlT    ctrl,
	output logic              busStart,
	output logic              busWrite,
	output logic              irLoad
);
	cpu16Pkg::stateT state;
	cpu16Pkg::stateT nextState;
	cpu16Pkg::aluOpT functOp;
	logic            runQ;      // Holds off the first fetch until out of reset
	logic            busBusy;   // Transfer issued, waiting on busDone

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state   <= cpu16Pkg::FETCH;
			runQ    <= 1'b0;
			busBusy <= 1'b0;
		end else begin
			state <= nextState;
			runQ  <= 1'b1;
			if (busDone) begin
				busBusy <= 1'b0;
			end else if (busStart) begin
				busBusy <= 1'b1;
			end
		end
	end

	// One transfer per visit to FETCH or MEMORY
	assign busStart = runQ && !busBusy &&
		(state == cpu16Pkg::FETCH || state == cpu16Pkg::MEMORY);
	assign busWrite = (state == cpu16Pkg::MEMORY) && (dec.opcode == cpu16Pkg::SW);
	assign irLoad   = (state == cpu16Pkg::FETCH) && busDone;

	always_comb begin
		case (dec.funct)
			3'd0:    functOp = cpu16Pkg::ALU_AND;
			3'd1:    functOp = cpu16Pkg::ALU_ADD;
			3'd2:    functOp = cpu16Pkg::ALU_SUB;
			3'd3:    functOp = cpu16Pkg::ALU_SLL;
			3'd4:    functOp = cpu16Pkg::ALU_SRL;
			default: functOp = cpu16Pkg::ALU_ADD;  // Unused funct codes
		endcase
	end

	always_comb begin
		ctrl      = '0;
		nextState = state;
		case (state)
			cpu16Pkg::FETCH: begin
				ctrl.aluSrcA = cpu16Pkg::SRCA_PC;     // PC + 1
				ctrl.aluSrcB = cpu16Pkg::SRCB_ONE;
				ctrl.aluOp   = cpu16Pkg::ALU_ADD;
				ctrl.pcSrc   = cpu16Pkg::PC_ALU;
				ctrl.pcWrite = busDone;
				if (busDone) begin
					nextState = cpu16Pkg::DECODE;
				end
			end
			cpu16Pkg::DECODE: begin
				ctrl.aluSrcA = cpu16Pkg::SRCA_PC;     // Branch target into ALUOut
				ctrl.aluSrcB = cpu16Pkg::SRCB_IMM;
				ctrl.aluOp   = cpu16Pkg::ALU_ADD;
				nextState    = cpu16Pkg::EXECUTE;
			end
			cpu16Pkg::EXECUTE: begin
				nextState = cpu16Pkg::FETCH;
				case (dec.opcode)
					cpu16Pkg::RTYPE: begin
						ctrl.aluSrcA = cpu16Pkg::SRCA_A;
						ctrl.aluSrcB = cpu16Pkg::SRCB_B;
						ctrl.aluOp   = functOp;
						nextState    = cpu16Pkg::WRITEBACK;
					end
					cpu16Pkg::ADDI, cpu16Pkg::ANDI: begin
						ctrl.aluSrcA = cpu16Pkg::SRCA_A;
						ctrl.aluSrcB = cpu16Pkg::SRCB_IMM;
						ctrl.aluOp   = (dec.opcode == cpu16Pkg::ANDI) ?
							cpu16Pkg::ALU_AND : cpu16Pkg::ALU_ADD;
						nextState    = cpu16Pkg::WRITEBACK;
					end
					cpu16Pkg::LW, cpu16Pkg::SW: begin
						ctrl.aluSrcA = cpu16Pkg::SRCA_B;      // rs + imm
						ctrl.aluSrcB = cpu16Pkg::SRCB_IMM;
						ctrl.aluOp   = cpu16Pkg::ALU_ADD;
						nextState    = cpu16Pkg::MEMORY;
					end
					cpu16Pkg::BEQ, cpu16Pkg::BNE: begin
						ctrl.aluSrcA  = cpu16Pkg::SRCA_A;
						ctrl.aluSrcB  = cpu16Pkg::SRCB_B;
						ctrl.aluOp    = cpu16Pkg::ALU_SUB;
						ctrl.pcSrc    = cpu16Pkg::PC_ALUOUT;
						ctrl.branchEq = (dec.opcode == cpu16Pkg::BEQ);
						ctrl.branchNe = (dec.opcode == cpu16Pkg::BNE);
					end
					cpu16Pkg::JMP: begin
						ctrl.pcSrc   = cpu16Pkg::PC_JUMP;
						ctrl.pcWrite = 1'b1;
					end
					default: ;
				endcase
			end
			cpu16Pkg::MEMORY: begin
				// Same ALU setup as EXECUTE keeps ALUOut, the bus address, steady
				ctrl.aluSrcA = cpu16Pkg::SRCA_B;
				ctrl.aluSrcB = cpu16Pkg::SRCB_IMM;
				ctrl.aluOp   = cpu16Pkg::ALU_ADD;
				ctrl.addrSel = 1'b1;
				if (busDone) begin
					nextState = (dec.opcode == cpu16Pkg::SW) ?
						cpu16Pkg::FETCH : cpu16Pkg::WRITEBACK;
				end
			end
			cpu16Pkg::WRITEBACK: begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst   = (dec.opcode == cpu16Pkg::RTYPE);
				ctrl.memToReg = (dec.opcode == cpu16Pkg::LW);
				nextState     = cpu16Pkg::FETCH;
			end
			default: nextState = cpu16Pkg::FETCH;
		endcase
	end

endmodule

// File: verilog/cpu16Pkg.sv
`include "cpu16_params.svh"

package cpu16Pkg;

	typedef enum logic [`CPU16_OP_W-1:0] {
		RTYPE = 4'h0,
		JMP   = 4'h1,
		ANDI  = 4'h2,
		ADDI  = 4'h3,
		LW    = 4'h4,
		SW    = 4'h5,
		BEQ   = 4'h6,
		BNE   = 4'h7
	} opcodeT;

	typedef enum logic [2:0] {
		ALU_AND = 3'd0,
		ALU_ADD = 3'd1,
		ALU_SUB = 3'd2,
		ALU_SLL = 3'd3,
		ALU_SRL = 3'd4
	} aluOpT;

	typedef enum logic [2:0] {FETCH, DECODE, EXECUTE, MEMORY, WRITEBACK} stateT;

	// Datapath mux selects
	typedef enum logic [1:0] {PC_ALU, PC_ALUOUT, PC_JUMP} pcSrcT;
	typedef enum logic [1:0] {SRCA_PC, SRCA_A, SRCA_B} srcAT;
	typedef enum logic [1:0] {SRCB_B, SRCB_ONE, SRCB_IMM} srcBT;

	typedef struct packed {
		opcodeT                     opcode;
		logic [`CPU16_REG_W-1:0]    rs;
		logic [`CPU16_REG_W-1:0]    rt;     // First source, I-type and LW destination
		logic [`CPU16_REG_W-1:0]    rd;
		logic [`CPU16_FUNCT_W-1:0]  funct;
		logic [`CPU16_DATA_W-1:0]   imm;    // Already sign-extended
		logic [`CPU16_JMP_W-1:0]    jump;
	} decodedT;

	typedef struct packed {
		logic   pcWrite;
		logic   branchEq;
		logic   branchNe;
		pcSrcT  pcSrc;
		srcAT   aluSrcA;
		srcBT   aluSrcB;
		aluOpT  aluOp;
		logic   regWrite;
		logic   regDst;     // 1 writes rd, 0 writes rt
		logic   memToReg;
		logic   addrSel;    // 1 puts ALUOut on the bus address
	} ctrlT;

	typedef struct packed {
		logic                     psel;
		logic                     penable;
		logic                     pwrite;
		logic [`CPU16_DATA_W-1:0] paddr;
		logic [`CPU16_DATA_W-1:0] pwdata;
	} apbReqT;

	typedef struct packed {
		logic [`CPU16_DATA_W-1:0] prdata;
		logic                     pready;
	} apbRspT;

endpackage

// File: verilog/cpu16Top.sv
`timescale 1ns/1ns
`include "cpu16_params.svh"

module cpu16Top (
	input  logic             clk,
	input  logic             reset,
	input  cpu16Pkg::apbRspT apbRsp,
	output cpu16Pkg::apbReqT apbReq
);
	cpu16Pkg::decodedT        dec;
	cpu16Pkg::ctrlT           ctrl;
	logic                     busStart;
	logic                     busWrite;
	logic                     busDone;
	logic                     irLoad;
	logic [`CPU16_DATA_W-1:0] busAddr;
	logic [`CPU16_DATA_W-1:0] busWdata;
	logic [`CPU16_DATA_W-1:0] busRdata;

	instrDecoder uDecoder (
		.clk      (clk),
		.reset    (reset),
		.irLoad   (irLoad),
		.busRdata (busRdata),
		.dec      (dec)
	);

	controlFsm uFsm (
		.clk      (clk),
		.reset    (reset),
		.dec      (dec),
		.busDone  (busDone),
		.ctrl     (ctrl),
		.busStart (busStart),
		.busWrite (busWrite),
		.irLoad   (irLoad)
	);

	execUnit uExec (
		.clk      (clk),
		.reset    (reset),
		.ctrl     (ctrl),
		.dec      (dec),
		.busRdata (busRdata),
		.busDone  (busDone),
		.busAddr  (busAddr),
		.busWdata (busWdata)
	);

	apbRequester uApb (
		.clk      (clk),
		.reset    (reset),
		.busStart (busStart),
		.busWrite (busWrite),
		.busAddr  (busAddr),
		.busWdata (busWdata),
		.apbRsp   (apbRsp),
		.apbReq   (apbReq),
		.busDone  (busDone),
		.busRdata (busRdata)
	);

endmodule

// File: verilog/cpu16_params.svh
`ifndef CPU16_PARAMS_SVH
`define CPU16_PARAMS_SVH

// Word width, also used for word addresses
`define CPU16_DATA_W  16

`define CPU16_REG_CNT 8     // Register file depth
`define CPU16_REG_W   3     // Register index width

// Instruction field widths
`define CPU16_OP_W    4
`define CPU16_FUNCT_W 3
`define CPU16_IMM_W   6     // Sign-extended to the data width
`define CPU16_JMP_W   12    // Low PC bits replaced by JMP

`endif

// File: verilog/execUnit.sv
`timescale 1ns/1ns
`include "cpu16_params.svh"

module execUnit (
	input  logic                     clk,
	input  logic                     reset,
	input  cpu16Pkg::ctrlT           ctrl,
	input  cpu16Pkg::decodedT        dec,
	input  logic [`CPU16_DATA_W-1:0] busRdata,
	input  logic                     busDone,
	output logic [`CPU16_DATA_W-1:0] busAddr,
	output logic [`CPU16_DATA_W-1:0] busWdata
);
	logic [`CPU16_DATA_W-1:0] regFile [`CPU16_REG_CNT];
	logic [`CPU16_DATA_W-1:0] pc;
	logic [`CPU16_DATA_W-1:0] regA;     // Holds rt
	logic [`CPU16_DATA_W-1:0] regB;     // Holds rs
	logic [`CPU16_DATA_W-1:0] aluOut;
	logic [`CPU16_DATA_W-1:0] mdr;
	logic [`CPU16_DATA_W-1:0] opA;
	logic [`CPU16_DATA_W-1:0] opB;
	logic [`CPU16_DATA_W-1:0] aluRes;
	logic [`CPU16_DATA_W-1:0] nextPc;
	logic [`CPU16_DATA_W-1:0] wbData;
	logic [`CPU16_REG_W-1:0]  wbReg;
	logic                     taken;

	assign wbReg  = ctrl.regDst ? dec.rd : dec.rt;
	assign wbData = ctrl.memToReg ? mdr : aluOut;

	// Register 0 is never written, so it stays at its reset value
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < `CPU16_REG_CNT; i++) begin
				regFile[i] <= '0;
			end
		end else if (ctrl.regWrite && wbReg != '0) begin
			regFile[wbReg] <= wbData;
		end
	end

	always_ff @(posedge clk) begin
		regA   <= regFile[dec.rt];
		regB   <= regFile[dec.rs];
		aluOut <= aluRes;
		if (busDone && ctrl.addrSel) begin
			mdr <= busRdata;    // Load data from the memory phase
		end
	end

	always_comb begin
		case (ctrl.aluSrcA)
			cpu16Pkg::SRCA_A: opA = regA;
			cpu16Pkg::SRCA_B: opA = regB;
			default:          opA = pc;
		endcase
		case (ctrl.aluSrcB)
			cpu16Pkg::SRCB_ONE: opB = `CPU16_DATA_W'(1);
			cpu16Pkg::SRCB_IMM: opB = dec.imm;
			default:            opB = regB;
		endcase
		case (ctrl.aluOp)
			cpu16Pkg::ALU_AND: aluRes = opA & opB;
			cpu16Pkg::ALU_SUB: aluRes = opA - opB;
			cpu16Pkg::ALU_SLL: aluRes = opA << opB;
			cpu16Pkg::ALU_SRL: aluRes = opA >> opB;
			default:           aluRes = opA + opB;
		endcase
	end

	// Branch compare rides on the SUB result
	assign taken = (ctrl.branchEq && aluRes == '0) || (ctrl.branchNe && aluRes != '0);

	always_comb begin
		case (ctrl.pcSrc)
			cpu16Pkg::PC_ALUOUT: nextPc = aluOut;
			cpu16Pkg::PC_JUMP:   nextPc = {pc[`CPU16_DATA_W-1:`CPU16_JMP_W], dec.jump};
			default:             nextPc = aluRes;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc <= '0;
		end else if (ctrl.pcWrite || taken) begin
			pc <= nextPc;
		end
	end

	assign busAddr  = ctrl.addrSel ? aluOut : pc;
	assign busWdata = regA;     // SW stores rt

endmodule

// File: verilog/instrDecoder.sv
`timescale 1ns/1ns
`include "cpu16_params.svh"

module instrDecoder (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     irLoad,
	input  logic [`CPU16_DATA_W-1:0] busRdata,
	output cpu16Pkg::decodedT        dec
);
	logic [`CPU16_DATA_W-1:0] ir;
	logic [`CPU16_IMM_W-1:0]  imm;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ir <= '0;
		end else if (irLoad) begin
			ir <= busRdata;     // Fetched word arrives with busDone
		end
	end

	assign imm = ir[`CPU16_IMM_W-1:0];

	// Fields overlap, only the ones the opcode needs get used
	always_comb begin
		dec.opcode = cpu16Pkg::opcodeT'(ir[`CPU16_DATA_W-1 -: `CPU16_OP_W]);
		dec.rt     = ir[11:9];
		dec.rs     = ir[8:6];
		dec.rd     = ir[5:3];
		dec.funct  = ir[`CPU16_FUNCT_W-1:0];
		dec.imm    = {{(`CPU16_DATA_W - `CPU16_IMM_W){imm[`CPU16_IMM_W-1]}}, imm};
		dec.jump   = ir[`CPU16_JMP_W-1:0];
	end

endmodule
